//--- hdl/fifo.sv
// Ring-buffer FIFO for one queue lane with registered pointers and empty/full flags
`timescale 1ns/100ps
`include "mq_cfg.svh"

module fifo
    import mq_pkg::*;
(
    input  logic clk,
    input  logic rst,
    lane_if.fifo q
);

    localparam int PTR_W = $clog2(`MQ_FIFO_DEPTH);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`MQ_FIFO_DEPTH - 1);

    // Storage slots
    mq_data_t mem [`MQ_FIFO_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr_inc;
    logic [PTR_W-1:0] wr_ptr_inc;
    logic             do_push;
    logic             do_pop;

    // Next slot around the ring
    // Wraps at the last slot, so any depth works
    assign rd_ptr_inc = (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
    assign wr_ptr_inc = (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;

    // Empty when both pointers meet
    assign q.empty = (wr_ptr == rd_ptr);

    // Full when one more write would catch up with the read pointer
    assign q.full = (wr_ptr_inc == rd_ptr);

    // Head entry, valid whenever the lane is not empty
    assign q.pop_data = mem[rd_ptr];

    // Push on full and pop on empty have no effect
    assign do_push = q.push && !q.full;
    assign do_pop  = q.pop && !q.empty;

    // Word is written into the slot under the write pointer
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= q.push_data;
        end
    end

    // Pointers advance independently, same-cycle push and pop is fine
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr_inc;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr_inc;
            end
        end
    end

endmodule : fifo

//--- hdl/lane_if.sv
// Interface for one queue lane: push, pop, data and flags, with writer, reader and fifo modports
`timescale 1ns/100ps

interface lane_if import mq_pkg::*; ();

    // Write side, driven by the push port
    logic     push;
    mq_data_t push_data;

    // Read side, driven by the pop port
    logic     pop;
    mq_data_t pop_data;

    // Lane flags from the FIFO
    logic     empty;
    logic     full;

    // Producer side
    modport writer (output push, output push_data, input full);

    // Consumer side, also sees full for the status word
    modport reader (output pop, input pop_data, input empty, input full);

    // FIFO mirrors both ports
    modport fifo (input push, input push_data, input pop,
                  output pop_data, output empty, output full);

endinterface : lane_if

//--- hdl/mq_cfg.svh
// Queue configuration defines: word width, lane count and FIFO depth per lane
`ifndef MQ_CFG_SVH
`define MQ_CFG_SVH

// Width of one queued word
`define MQ_DATA_WIDTH 32

// Number of lanes, a power of two
// Lane index width follows from it
`define MQ_NUM_LANES 4

// Slots per lane ring buffer
// One slot stays free to tell full from empty, so capacity is depth minus one
`define MQ_FIFO_DEPTH 4

// Bit position of the full mask in the status word
`define MQ_STAT_FULL_LSB 8

`endif

//--- hdl/mq_pkg.sv
// Shared queue types: data word, lane index, lane mask and Wishbone port state
`include "mq_cfg.svh"

package mq_pkg;

    // One queued word as carried on both buses
    typedef logic [`MQ_DATA_WIDTH-1:0] mq_data_t;

    // Lane number, log2 of the lane count
    typedef logic [$clog2(`MQ_NUM_LANES)-1:0] lane_idx_t;

    // One bit per lane
    // Used for the empty and full flags in the status word
    typedef logic [`MQ_NUM_LANES-1:0] lane_mask_t;

    // Wishbone slave port FSM
    // Idle until a request, wait on back-pressure, single-cycle ack
    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_WAIT,
        PORT_ACK
    } port_state_t;

endpackage : mq_pkg

//--- hdl/mq_top.sv
// Message queue top level: Wishbone producer and consumer ports over an array of lane FIFOs
`timescale 1ns/100ps
`include "mq_cfg.svh"

module mq_top
    import mq_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Producer bus
    input  logic       p_cyc,
    input  logic       p_stb,
    input  logic       p_we,
    input  lane_idx_t  p_adr,
    input  mq_data_t   p_dat_w,
    output logic       p_ack,

    // Consumer bus
    input  logic       c_cyc,
    input  logic       c_stb,
    input  logic [2:0] c_adr,
    output mq_data_t   c_dat_r,
    output logic       c_ack
);

    // One bundle per lane between the ports and its FIFO
    lane_if lanes [`MQ_NUM_LANES] ();

    // Producer side, write port
    wb_push_port i_push (
        .clk   (clk),
        .rst   (rst),
        .cyc   (p_cyc),
        .stb   (p_stb),
        .we    (p_we),
        .adr   (p_adr),
        .dat_w (p_dat_w),
        .ack   (p_ack),
        .lanes (lanes)
    );

    // Consumer side, read and status port
    wb_pop_port i_pop (
        .clk   (clk),
        .rst   (rst),
        .cyc   (c_cyc),
        .stb   (c_stb),
        .adr   (c_adr),
        .dat_r (c_dat_r),
        .ack   (c_ack),
        .lanes (lanes)
    );

    // Lane buffers
    for (genvar i = 0; i < `MQ_NUM_LANES; i++) begin : g_fifo
        fifo i_fifo (
            .clk (clk),
            .rst (rst),
            .q   (lanes[i])
        );
    end

endmodule : mq_top

//--- hdl/wb_pop_port.sv
// Wishbone classic slave that pops the addressed lane or returns the lane status word
`timescale 1ns/100ps
`include "mq_cfg.svh"

module wb_pop_port
    import mq_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cyc,
    input  logic       stb,
    input  logic [2:0] adr,
    output mq_data_t   dat_r,
    output logic       ack,
    lane_if.reader     lanes [`MQ_NUM_LANES]
);

    port_state_t state;
    port_state_t state_nxt;
    lane_idx_t   adr_lane;
    lane_idx_t   lane_q;
    lane_idx_t   rd_lane;
    logic        pop_q;
    logic        req;
    logic        rd_status;
    logic        load;
    lane_mask_t  empty_mask;
    lane_mask_t  full_mask;
    mq_data_t    head [`MQ_NUM_LANES];
    mq_data_t    status_word;

    assign req      = cyc && stb;
    // Low address bits pick the lane, bit 2 picks status
    assign adr_lane = adr[1:0];

    // Flags and head words from every lane
    for (genvar i = 0; i < `MQ_NUM_LANES; i++) begin : g_lane
        assign empty_mask[i] = lanes[i].empty;
        assign full_mask[i]  = lanes[i].full;
        assign head[i]       = lanes[i].pop_data;
        // One pop per data read, on the acked lane only
        assign lanes[i].pop  = (state == PORT_ACK) && pop_q && (lane_q == lane_idx_t'(i));
    end

    // Status word
    // Empty mask at the bottom, full mask at bit 8, rest zero
    always_comb begin
        status_word = '0;
        status_word[`MQ_NUM_LANES-1:0] = empty_mask;
        status_word[`MQ_STAT_FULL_LSB +: `MQ_NUM_LANES] = full_mask;
    end

    // A waiting read is always a data read of the latched lane
    assign rd_status = (state == PORT_IDLE) && adr[2];
    assign rd_lane   = (state == PORT_IDLE) ? adr_lane : lane_q;

    // FSM next state, load marks the edge that registers dat_r
    always_comb begin
        state_nxt = state;
        load      = 1'b0;
        case (state)
            PORT_IDLE: begin
                if (req) begin
                    if (adr[2] || !empty_mask[adr_lane]) begin
                        state_nxt = PORT_ACK;
                        load      = 1'b1;
                    end else begin
                        // Empty lane, stall until a word arrives
                        state_nxt = PORT_WAIT;
                    end
                end
            end
            PORT_WAIT: begin
                if (!cyc) begin
                    state_nxt = PORT_IDLE;
                end else if (!empty_mask[lane_q]) begin
                    state_nxt = PORT_ACK;
                    load      = 1'b1;
                end
            end
            PORT_ACK: state_nxt = PORT_IDLE;
            default:  state_nxt = PORT_IDLE;
        endcase
    end

    // State and latched request kind
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= PORT_IDLE;
            lane_q <= '0;
            pop_q  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == PORT_IDLE && req) begin
                lane_q <= adr_lane;
                pop_q  <= !adr[2];
            end
        end
    end

    // Read data registered on the edge before ack
    always_ff @(posedge clk) begin
        if (load) begin
            dat_r <= rd_status ? status_word : head[rd_lane];
        end
    end

    assign ack = (state == PORT_ACK);

endmodule : wb_pop_port

//--- hdl/wb_push_port.sv
// Wishbone classic slave that pushes producer writes into the addressed lane
`timescale 1ns/100ps
`include "mq_cfg.svh"

module wb_push_port
    import mq_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  lane_idx_t adr,
    input  mq_data_t  dat_w,
    output logic      ack,
    lane_if.writer    lanes [`MQ_NUM_LANES]
);

    port_state_t state;
    port_state_t state_nxt;
    lane_idx_t   lane_q;
    mq_data_t    data_q;
    logic        we_q;
    lane_mask_t  full_mask;
    logic        req;

    // Valid bus request
    assign req = cyc && stb;

    // Per-lane push strobes and flag gather
    for (genvar i = 0; i < `MQ_NUM_LANES; i++) begin : g_lane
        // Only the latched lane pushes, and only on a write
        assign lanes[i].push      = (state == PORT_ACK) && we_q && (lane_q == lane_idx_t'(i));
        assign lanes[i].push_data = data_q;
        assign full_mask[i]       = lanes[i].full;
    end

    // FSM next state
    always_comb begin
        state_nxt = state;
        case (state)
            PORT_IDLE: begin
                if (req) begin
                    // Reads are acked at once, writes to a full lane stall
                    if (!we || !full_mask[adr]) begin
                        state_nxt = PORT_ACK;
                    end else begin
                        state_nxt = PORT_WAIT;
                    end
                end
            end
            PORT_WAIT: begin
                // Master gave up the cycle
                if (!cyc) begin
                    state_nxt = PORT_IDLE;
                end else if (!full_mask[lane_q]) begin
                    state_nxt = PORT_ACK;
                end
            end
            // Ack lasts one cycle, master drops stb after it
            PORT_ACK: state_nxt = PORT_IDLE;
            default:  state_nxt = PORT_IDLE;
        endcase
    end

    // State and latched request
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= PORT_IDLE;
            lane_q <= '0;
            we_q   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == PORT_IDLE && req) begin
                lane_q <= adr;
                we_q   <= we;
            end
        end
    end

    // Write word held until the push
    always_ff @(posedge clk) begin
        if (state == PORT_IDLE && req) begin
            data_q <= dat_w;
        end
    end

    assign ack = (state == PORT_ACK);

endmodule : wb_push_port

//--- run.sh
#!/bin/sh
# Compile the message queue testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

top=tb_mq
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$top" -f tb.f -o "V$top"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$log"; then
    echo "Pass message found in $log"
    exit 0
else
    echo "Pass message not found in $log"
    exit 1
fi

//--- tb.f
+incdir+hdl
hdl/mq_pkg.sv
hdl/lane_if.sv
hdl/fifo.sv
hdl/wb_push_port.sv
hdl/wb_pop_port.sv
hdl/mq_top.sv
tests/tb_mq.sv

//--- tests/tb_mq.sv
// Testbench for mq_top with clock, reset, Wishbone master tasks, per-lane queue model and checks
`timescale 1ns/100ps
`include "mq_cfg.svh"

module tb_mq
    import mq_pkg::*;
();

    localparam int NUM_LANES  = `MQ_NUM_LANES;
    localparam int LANE_CAP   = `MQ_FIFO_DEPTH - 1;
    localparam int MAX_CYCLES = 4000;
    localparam int RAND_OPS   = 300;

    logic       clk;
    logic       rst;
    logic       p_cyc;
    logic       p_stb;
    logic       p_we;
    lane_idx_t  p_adr;
    mq_data_t   p_dat_w;
    logic       p_ack;
    logic       c_cyc;
    logic       c_stb;
    logic [2:0] c_adr;
    mq_data_t   c_dat_r;
    logic       c_ack;

    // Reference model with one queue per lane
    mq_data_t model [NUM_LANES][$];
    // Expected read data set once the ack is seen
    mq_data_t exp_dat;
    int       value_errors;
    int       protocol_errors;
    int       cycles;
    int       p_acks;
    int       c_acks;

    mq_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .p_cyc   (p_cyc),
        .p_stb   (p_stb),
        .p_we    (p_we),
        .p_adr   (p_adr),
        .p_dat_w (p_dat_w),
        .p_ack   (p_ack),
        .c_cyc   (c_cyc),
        .c_stb   (c_stb),
        .c_adr   (c_adr),
        .c_dat_r (c_dat_r),
        .c_ack   (c_ack)
    );

    always #50 clk = ~clk;

    // Ack counters sampled mid-cycle where ack is stable
    always @(negedge clk) begin
        if (p_ack) begin
            p_acks++;
        end
        if (c_ack) begin
            c_acks++;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Every consumer ack must carry the model's word or status
    a_read_data: assert property (@(posedge clk) disable iff (rst)
        c_ack |-> (c_dat_r == exp_dat))
        else begin
            value_errors++;
            $display("FAILED c_dat_r: got 0x%h, expected 0x%h", c_dat_r, exp_dat);
        end

    // Wishbone classic handshake rules
    a_p_ack_stb: assert property (@(posedge clk) disable iff (rst) p_ack |-> p_stb)
        else begin
            protocol_errors++;
            $display("Producer ack arrived without a strobe");
        end
    a_c_ack_stb: assert property (@(posedge clk) disable iff (rst) c_ack |-> c_stb)
        else begin
            protocol_errors++;
            $display("Consumer ack arrived without a strobe");
        end
    a_p_ack_pulse: assert property (@(posedge clk) disable iff (rst) p_ack |=> !p_ack)
        else begin
            protocol_errors++;
            $display("Producer ack lasted longer than one cycle");
        end
    a_c_ack_pulse: assert property (@(posedge clk) disable iff (rst) c_ack |=> !c_ack)
        else begin
            protocol_errors++;
            $display("Consumer ack lasted longer than one cycle");
        end

    // Status word from the model with the empty mask in 3:0 and the full mask in 11:8
    function automatic mq_data_t model_status();
        mq_data_t s;
        s = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            s[i]     = (model[i].size() == 0);
            s[8 + i] = (model[i].size() == LANE_CAP);
        end
        return s;
    endfunction

    // Producer write
    // Model takes the word when the ack shows
    task automatic write_lane(input lane_idx_t lane, input mq_data_t data);
        @(posedge clk);
        p_cyc   <= 1'b1;
        p_stb   <= 1'b1;
        p_we    <= 1'b1;
        p_adr   <= lane;
        p_dat_w <= data;
        @(negedge clk);
        while (!p_ack) @(negedge clk);
        model[lane].push_back(data);
        @(posedge clk);
        p_cyc <= 1'b0;
        p_stb <= 1'b0;
        p_we  <= 1'b0;
    endtask

    // Consumer read of a lane or of the status word
    task automatic read_request(input logic status, input lane_idx_t lane);
        @(posedge clk);
        c_cyc <= 1'b1;
        c_stb <= 1'b1;
        c_adr <= {status, lane};
        @(negedge clk);
        while (!c_ack) @(negedge clk);
        if (status) begin
            exp_dat = model_status();
        end else if (model[lane].size() == 0) begin
            protocol_errors++;
            $display("Data read of lane %0d completed while the model lane is empty", lane);
        end else begin
            exp_dat = model[lane].pop_front();
        end
        @(posedge clk);
        c_cyc <= 1'b0;
        c_stb <= 1'b0;
    endtask

    task automatic read_lane(input lane_idx_t lane);
        read_request(1'b0, lane);
    endtask

    task automatic read_status();
        read_request(1'b1, '0);
    endtask

    // Random writes only to lanes the model shows not full
    task automatic random_writes(input int n);
        int lane;
        int tries;
        for (int k = 0; k < n; k++) begin
            lane  = $urandom % NUM_LANES;
            tries = 0;
            while (model[lane].size() >= LANE_CAP) begin
                lane = (lane + 1) % NUM_LANES;
                tries++;
                if (tries == NUM_LANES) begin
                    @(posedge clk);
                    tries = 0;
                end
            end
            write_lane(lane_idx_t'(lane), $urandom);
        end
    endtask

    // Random reads only of lanes the model shows non-empty
    task automatic random_reads(input int n);
        int lane;
        int tries;
        for (int k = 0; k < n; k++) begin
            lane  = $urandom % NUM_LANES;
            tries = 0;
            while (model[lane].size() == 0) begin
                lane = (lane + 1) % NUM_LANES;
                tries++;
                if (tries == NUM_LANES) begin
                    @(posedge clk);
                    tries = 0;
                end
            end
            read_lane(lane_idx_t'(lane));
        end
    endtask

    initial begin
        int acks_before;
        void'($urandom(32'hfb00));
        clk     = 1'b0;
        rst     = 1'b1;
        p_cyc   = 1'b0;
        p_stb   = 1'b0;
        p_we    = 1'b0;
        p_adr   = '0;
        p_dat_w = '0;
        c_cyc   = 1'b0;
        c_stb   = 1'b0;
        c_adr   = '0;
        exp_dat = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Idle buses and empty lanes after reset
        @(negedge clk);
        a_reset_acks: assert (!p_ack && !c_ack)
            else begin
                protocol_errors++;
                $display("An ack is high right after reset");
            end
        read_status();

        // Order within one lane
        for (int k = 0; k < LANE_CAP; k++) begin
            write_lane(0, $urandom);
        end
        for (int k = 0; k < LANE_CAP; k++) begin
            read_lane(0);
        end

        // Interleaved writes over all lanes and a lane-by-lane drain
        for (int r = 0; r < LANE_CAP; r++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                write_lane(lane_idx_t'(l), $urandom);
            end
            read_status();
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int k = 0; k < LANE_CAP; k++) begin
                read_lane(lane_idx_t'(l));
            end
            read_status();
        end

        // Write to a full lane stalls until one word is popped
        for (int k = 0; k < LANE_CAP; k++) begin
            write_lane(2, $urandom);
        end
        acks_before = p_acks;
        fork
            write_lane(2, $urandom);
            begin
                repeat (6) @(posedge clk);
                read_status();
                a_full_stall: assert (p_acks == acks_before)
                    else begin
                        protocol_errors++;
                        $display("Write to a full lane was acknowledged");
                    end
                read_lane(2);
            end
        join
        read_status();
        for (int k = 0; k < LANE_CAP; k++) begin
            read_lane(2);
        end

        // Read of an empty lane waits for the producer
        acks_before = c_acks;
        fork
            read_lane(1);
            begin
                repeat (6) @(posedge clk);
                a_empty_stall: assert (c_acks == acks_before)
                    else begin
                        protocol_errors++;
                        $display("Read of an empty lane was acknowledged");
                    end
                write_lane(1, $urandom);
            end
        join

        // Concurrent random traffic
        fork
            random_writes(RAND_OPS);
            random_reads(RAND_OPS);
        join
        read_status();
        repeat (2) @(posedge clk);

        $display("Run done: %0d value errors, %0d protocol errors", value_errors,
                 protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : tb_mq
